// File: common/rename_defs.svh
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// architectural and physical register file sizes
`define AREG_NUM 32
`define PREG_NUM 48

// pregs left over after the identity mapping, all start on the free list
`define FREE_NUM (`PREG_NUM - `AREG_NUM)

// in-flight window
`define ROB_SIZE 32

// index widths
`define AREG_W 5 // log2(AREG_NUM)
`define PREG_W 6 // covers 0..47
`define ROB_W 5 // log2(ROB_SIZE)
`define FREE_W 4 // log2(FREE_NUM)

`endif

// File: common/rename_pkg.sv
`default_nettype none

`include "rename_defs.svh"

package rename_pkg;

    typedef logic [`AREG_W-1:0] areg_t; // x0..x31
    typedef logic [`PREG_W-1:0] preg_t; // p0..p47
    typedef logic [`ROB_W-1:0] rob_idx_t;

    // one instruction from dispatch
    typedef struct packed {
        logic  valid;
        areg_t rs1;
        areg_t rs2;
        areg_t rd;
        logic  rd_valid; // instruction writes rd
    } dispatch_req_t;

    // renamed operands, same cycle as the request
    typedef struct packed {
        preg_t    rs1_preg;
        logic     rs1_ready;
        preg_t    rs2_preg;
        logic     rs2_ready;
        preg_t    rd_preg;  // zero when no destination
        preg_t    old_preg; // previous mapping of rd
        rob_idx_t rob_idx;
    } rename_resp_t;

    // completion broadcast
    typedef struct packed {
        logic     valid;
        preg_t    preg;
        rob_idx_t rob_idx;
    } cdb_t;

    // head of rob leaving the window
    typedef struct packed {
        logic  valid;
        logic  rd_valid;
        areg_t areg;
        preg_t preg;
        preg_t old_preg; // goes back to the free list
    } retire_t;

    typedef enum logic [1:0] {rob_free, rob_wait, rob_done} rob_state_e;

endpackage

`default_nettype wire

// File: rename/free_list.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module free_list import rename_pkg::*; (
    input  logic  clock,
    input  logic  rst,
    input  logic  alloc,        // pop head
    output preg_t head_preg,
    output logic  empty,
    input  logic  release_en,   // push at tail, from retirement
    input  preg_t release_preg
);

    preg_t             fifo [`FREE_NUM];
    logic [`FREE_W-1:0] head; // wraps at FREE_NUM
    logic [`FREE_W-1:0] tail;
    logic [`FREE_W:0]   count; // 0..FREE_NUM

    assign head_preg = fifo[head];
    assign empty     = (count == '0);

    always_ff @(posedge clock) begin
        if (rst) begin
            // p32..p47 in order
            for (int i = 0; i < `FREE_NUM; i++) begin
                fifo[i] <= preg_t'(`AREG_NUM + i);
            end
            head  <= '0;
            tail  <= '0; // full, so tail meets head
            count <= (`FREE_W+1)'(`FREE_NUM);
        end else begin
            if (release_en) begin
                fifo[tail] <= release_preg;
                tail       <= tail + 1'b1;
            end
            if (alloc) begin
                head <= head + 1'b1;
            end
            case ({alloc, release_en})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: ; // both or neither
            endcase
        end
    end

    // top only allocates with a free entry available
    a_no_alloc_empty: assert property (@(posedge clock) disable iff (rst)
        alloc |-> !empty)
        else $error("free_list: alloc while empty");

    // a full list means no destination is outstanding, nothing can retire one
    a_no_release_full: assert property (@(posedge clock) disable iff (rst)
        release_en |-> (count != (`FREE_W+1)'(`FREE_NUM)))
        else $error("free_list: release of p%0d while full", release_preg);

endmodule

`default_nettype wire

// File: rename/map_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module map_table import rename_pkg::*; (
    input  logic  clock,
    input  logic  rst,
    input  areg_t rs1,
    input  areg_t rs2,
    input  areg_t rd,
    input  logic  write,     // remap rd this edge
    input  preg_t new_preg,  // free list head
    input  cdb_t  cdb,
    output preg_t rs1_preg,
    output preg_t rs2_preg,
    output preg_t old_preg,
    output logic  rs1_ready,
    output logic  rs2_ready
);

    preg_t                map [`AREG_NUM]; // speculative areg -> preg
    logic [`PREG_NUM-1:0] ready;           // one bit per preg

    // lookups see the table before this cycle's write
    assign rs1_preg = map[rs1];
    assign rs2_preg = map[rs2];
    assign old_preg = map[rd];

    // bypass a completion landing this same cycle
    assign rs1_ready = ready[rs1_preg] | (cdb.valid && (cdb.preg == rs1_preg));
    assign rs2_ready = ready[rs2_preg] | (cdb.valid && (cdb.preg == rs2_preg));

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `AREG_NUM; i++) begin
                map[i] <= preg_t'(i); // identity
            end
            ready <= '1; // everything committed at reset
        end else begin
            if (write) begin
                map[rd]         <= new_preg;
                ready[new_preg] <= 1'b0; // new producer in flight
            end
            // new_preg comes off the free list so it never collides with cdb.preg
            if (cdb.valid) begin
                ready[cdb.preg] <= 1'b1;
            end
        end
    end

    // x0 stays hardwired to p0
    a_no_x0_write: assert property (@(posedge clock) disable iff (rst)
        write |-> (rd != '0))
        else $error("map_table: write to x0, new_preg %0d", new_preg);

    // a preg handed out by the free list has already been written back
    // before it was released
    a_alloc_ready: assert property (@(posedge clock) disable iff (rst)
        write |-> ready[new_preg])
        else $error("map_table: allocated preg %0d still pending", new_preg);

endmodule

`default_nettype wire

// File: rename/retire_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module retire_map import rename_pkg::*; (
    input  logic                   clock,
    input  logic                   rst,
    input  retire_t                retire,
    output preg_t [`AREG_NUM-1:0] committed_map
);

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `AREG_NUM; i++) begin
                committed_map[i] <= preg_t'(i); // identity
            end
        end else if (retire.valid && retire.rd_valid) begin
            committed_map[retire.areg] <= retire.preg;
        end
    end

    // in-order retirement means the previous writer of areg has already
    // committed, so the speculative old mapping matches the committed one
    a_old_matches: assert property (@(posedge clock) disable iff (rst)
        (retire.valid && retire.rd_valid)
            |-> (committed_map[retire.areg] == retire.old_preg))
        else $error("retire_map: x%0d committed p%0d, rob old_preg p%0d",
                    retire.areg, committed_map[retire.areg], retire.old_preg);

endmodule

`default_nettype wire

// File: rob/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module reorder_buffer import rename_pkg::*; (
    input  logic     clock,
    input  logic     rst,
    input  logic     push,          // accepted dispatch
    input  logic     push_rd_valid,
    input  areg_t    push_areg,
    input  preg_t    push_preg,
    input  preg_t    push_old_preg,
    output rob_idx_t tail,          // slot the next push lands in
    output logic     full,
    input  cdb_t     cdb,
    output retire_t  retire
);

    // entry state, reset to free
    rob_state_e state [`ROB_SIZE];

    // payload, written on push only
    logic [`ROB_SIZE-1:0] dest_q;
    areg_t                areg_q     [`ROB_SIZE];
    preg_t                preg_q     [`ROB_SIZE];
    preg_t                old_preg_q [`ROB_SIZE];

    rob_idx_t       head;  // oldest entry
    logic [`ROB_W:0] count; // 0..ROB_SIZE
    logic           pop;

    assign full = (count == (`ROB_W+1)'(`ROB_SIZE));

    // head slot goes free after pop, so an empty rob never shows done here
    assign pop = (state[head] == rob_done);

    always_comb begin
        retire.valid    = pop;
        retire.rd_valid = dest_q[head];
        retire.areg     = areg_q[head];
        retire.preg     = preg_q[head];
        retire.old_preg = old_preg_q[head];
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `ROB_SIZE; i++) begin
                state[i] <= rob_free;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // push never hits the head slot, top holds off when full
            if (push) begin
                state[tail] <= rob_wait;
                tail        <= tail + 1'b1; // wraps at ROB_SIZE
            end
            if (cdb.valid) begin
                state[cdb.rob_idx] <= rob_done;
            end
            // head is already done so no completion targets it this cycle
            if (pop) begin
                state[head] <= rob_free;
                head        <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            dest_q[tail]     <= push_rd_valid;
            areg_q[tail]     <= push_areg;
            preg_q[tail]     <= push_preg;     // zero without destination
            old_preg_q[tail] <= push_old_preg;
        end
    end

    // completions must come from something dispatched and not yet retired
    a_cdb_live: assert property (@(posedge clock) disable iff (rst)
        cdb.valid |-> (state[cdb.rob_idx] != rob_free))
        else $error("reorder_buffer: completion to free slot %0d, preg p%0d",
                    cdb.rob_idx, cdb.preg);

endmodule

`default_nettype wire

// File: rtl/rename_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module rename_core import rename_pkg::*; (
    input  logic                   clock,
    input  logic                   rst,
    input  dispatch_req_t          dispatch,
    output logic                   dispatch_ready,
    output rename_resp_t           rename,
    input  cdb_t                   cdb,
    output retire_t                retire,
    output preg_t [`AREG_NUM-1:0] committed_map
);

    logic     has_dest;   // rd_valid and rd not x0
    logic     fire;       // dispatch accepted this edge
    logic     fire_dest;  // accepted and allocates
    logic     retire_dest;
    logic     rob_full;
    logic     fl_empty;
    preg_t    fl_head;
    preg_t    rs1_preg;
    preg_t    rs2_preg;
    preg_t    old_preg;
    logic     rs1_ready;
    logic     rs2_ready;
    rob_idx_t rob_tail;

    assign has_dest = dispatch.rd_valid && (dispatch.rd != '0);

    // only back-pressure point, blocks never recheck
    assign dispatch_ready = !rob_full && (!fl_empty || !has_dest);
    assign fire           = dispatch.valid && dispatch_ready;
    assign fire_dest      = fire && has_dest;
    assign retire_dest    = retire.valid && retire.rd_valid;

    always_comb begin
        rename.rs1_preg  = rs1_preg;
        rename.rs1_ready = rs1_ready;
        rename.rs2_preg  = rs2_preg;
        rename.rs2_ready = rs2_ready;
        rename.rd_preg   = has_dest ? fl_head : '0;  // zero when nothing allocated
        rename.old_preg  = has_dest ? old_preg : '0;
        rename.rob_idx   = rob_tail;
    end

    map_table map_table_ins (
        .clock     (clock),
        .rst       (rst),
        .rs1       (dispatch.rs1),
        .rs2       (dispatch.rs2),
        .rd        (dispatch.rd),
        .write     (fire_dest),
        .new_preg  (fl_head),
        .cdb       (cdb),
        .rs1_preg  (rs1_preg),
        .rs2_preg  (rs2_preg),
        .old_preg  (old_preg),
        .rs1_ready (rs1_ready),
        .rs2_ready (rs2_ready)
    );

    free_list free_list_ins (
        .clock        (clock),
        .rst          (rst),
        .alloc        (fire_dest),
        .head_preg    (fl_head),
        .empty        (fl_empty),
        .release_en   (retire_dest),     // old mapping is dead once committed
        .release_preg (retire.old_preg)
    );

    reorder_buffer reorder_buffer_ins (
        .clock         (clock),
        .rst           (rst),
        .push          (fire),
        .push_rd_valid (has_dest),
        .push_areg     (dispatch.rd),
        .push_preg     (rename.rd_preg),
        .push_old_preg (rename.old_preg),
        .tail          (rob_tail),
        .full          (rob_full),
        .cdb           (cdb),
        .retire        (retire)
    );

    retire_map retire_map_ins (
        .clock         (clock),
        .rst           (rst),
        .retire        (retire),
        .committed_map (committed_map)
    );

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/rename_pkg.sv
rename/map_table.sv
rename/free_list.sv
rename/retire_map.sv
rob/reorder_buffer.sv
rtl/rename_core.sv
tests/tb_rename_core.sv

// File: tests/tb_rename_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_defs.svh"

module tb_rename_core import rename_pkg::*; ();

    localparam int STIM_CYCLES = 1220; // sum of all phase lengths
    localparam int LIMIT       = 4 * (STIM_CYCLES + 5); // includes reset and the closing edge

    // one in-flight instruction as the model sees it
    typedef struct packed {
        rob_idx_t idx;
        logic     dest;
        areg_t    areg;
        preg_t    preg;
        preg_t    old_preg;
        logic     done;
    } flight_t;

    logic                  clock;
    logic                  rst;
    dispatch_req_t         dispatch;
    cdb_t                  cdb;
    logic                  dispatch_ready;
    rename_resp_t          rename;
    retire_t               retire;
    preg_t [`AREG_NUM-1:0] committed_map;

    // reference model state
    preg_t                 m_map [`AREG_NUM];
    logic [`PREG_NUM-1:0]  m_ready;
    preg_t                 m_free [$];   // fifo order of free pregs
    flight_t               m_flight [$]; // oldest first
    preg_t [`AREG_NUM-1:0] m_committed;
    rob_idx_t              m_tail;

    // expected port values for the current cycle
    logic                  exp_ready;
    rename_resp_t          exp_rename;
    logic                  exp_rd_known; // head value undefined on empty list
    retire_t               exp_retire;
    preg_t [`AREG_NUM-1:0] exp_committed;

    logic [31:0] rng = 32'h7af4;
    int          p_valid;
    int          p_dest;
    int          p_cdb;
    logic        rd_nonzero;
    string       test_name = "reset";
    int          cycle_count = 0;
    int          err_ready = 0;
    int          err_rename = 0;
    int          err_retire = 0;
    int          err_map = 0;

    rename_core dut_i (
        .clock          (clock),
        .rst            (rst),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .rename         (rename),
        .cdb            (cdb),
        .retire         (retire),
        .committed_map  (committed_map)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock; // 40 ns period
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic can_accept(input dispatch_req_t d);
        return (m_flight.size() < `ROB_SIZE) &&
               ((m_free.size() > 0) || !(d.rd_valid && (d.rd != '0)));
    endfunction

    function automatic rename_resp_t strip_rd(input rename_resp_t r);
        r.rd_preg = '0; // compared on its own
        return r;
    endfunction

    task automatic model_reset;
        for (int i = 0; i < `AREG_NUM; i++) begin
            m_map[i]       = preg_t'(i);
            m_committed[i] = preg_t'(i);
        end
        m_ready = '1;
        m_free.delete();
        for (int i = 0; i < `FREE_NUM; i++) begin
            m_free.push_back(preg_t'(`AREG_NUM + i)); // p32 first
        end
        m_flight.delete();
        m_tail = '0;
    endtask

    // apply the inputs the DUT sees at this edge
    task automatic model_step;
        logic    acc;
        logic    dest;
        flight_t e;
        preg_t   p;
        dest = dispatch.rd_valid && (dispatch.rd != '0);
        acc  = dispatch.valid && can_accept(dispatch); // pre-edge state
        if (m_flight.size() > 0 && m_flight[0].done) begin
            e = m_flight.pop_front();
            if (e.dest) begin
                m_free.push_back(e.old_preg);
                m_committed[e.areg] = e.preg;
            end
        end
        if (acc) begin
            p          = '0;
            e.old_preg = '0;
            if (dest) begin
                p                 = m_free.pop_front();
                e.old_preg        = m_map[dispatch.rd];
                m_map[dispatch.rd] = p;
                m_ready[p]        = 1'b0;
            end
            e.idx  = m_tail;
            e.dest = dest;
            e.areg = dispatch.rd; // kept even without destination
            e.preg = p;
            e.done = 1'b0;
            m_flight.push_back(e);
            m_tail = m_tail + 1'b1;
        end
        if (cdb.valid) begin
            foreach (m_flight[k]) begin
                if (m_flight[k].idx == cdb.rob_idx) m_flight[k].done = 1'b1;
            end
            m_ready[cdb.preg] = 1'b1;
        end
    endtask

    // expected outputs for next cycle's inputs
    task automatic predict(input dispatch_req_t d, input cdb_t c);
        rename_resp_t r;
        retire_t      t;
        logic         dest;
        dest        = d.rd_valid && (d.rd != '0);
        r.rs1_preg  = m_map[d.rs1];
        r.rs1_ready = m_ready[r.rs1_preg] || (c.valid && (c.preg == r.rs1_preg)); // bypass
        r.rs2_preg  = m_map[d.rs2];
        r.rs2_ready = m_ready[r.rs2_preg] || (c.valid && (c.preg == r.rs2_preg));
        r.rd_preg   = (dest && m_free.size() > 0) ? m_free[0] : '0;
        r.old_preg  = dest ? m_map[d.rd] : '0;
        r.rob_idx   = m_tail;
        t = '0;
        if (m_flight.size() > 0 && m_flight[0].done) begin
            t.valid    = 1'b1;
            t.rd_valid = m_flight[0].dest;
            t.areg     = m_flight[0].areg;
            t.preg     = m_flight[0].preg;
            t.old_preg = m_flight[0].old_preg;
        end
        exp_ready     <= can_accept(d);
        exp_rename    <= r;
        exp_rd_known  <= !(dest && m_free.size() == 0);
        exp_retire    <= t;
        exp_committed <= m_committed;
    endtask

    task automatic set_phase(input int cyc);
        p_valid    = 0;
        p_dest     = 0;
        p_cdb      = 0;
        rd_nonzero = 1'b0;
        if (cyc < 10) begin
            test_name = "reset_state";
        end else if (cyc < 40) begin
            test_name  = "fill_free_list"; // dests only and nothing completes
            p_valid    = 100;
            p_dest     = 100;
            rd_nonzero = 1'b1;
        end else if (cyc < 100) begin
            test_name = "drain_dests";
            p_cdb = 100;
        end else if (cyc < 160) begin
            test_name = "fill_rob"; // no dests so the rob fills at 32
            p_valid = 100;
        end else if (cyc < 220) begin
            test_name = "drain_rob";
            p_cdb = 100;
        end else begin
            test_name = "random";
            p_valid   = 80;
            p_dest    = 70;
            p_cdb     = 60;
        end
    endtask

    task automatic drive_next;
        dispatch_req_t d;
        cdb_t          c;
        int            waiting [$];
        int            k;
        d = '0;
        c = '0;
        d.valid    = (next_rand() % 100) < p_valid;
        d.rs1      = areg_t'(next_rand());
        d.rs2      = areg_t'(next_rand());
        d.rd_valid = (next_rand() % 100) < p_dest;
        d.rd       = rd_nonzero ? areg_t'(1 + next_rand() % 31) : areg_t'(next_rand());
        foreach (m_flight[i]) begin
            if (!m_flight[i].done) waiting.push_back(i);
        end
        if (waiting.size() > 0 && (next_rand() % 100) < p_cdb) begin
            k         = waiting[next_rand() % waiting.size()]; // random completion order
            c.valid   = 1'b1;
            c.preg    = m_flight[k].preg;
            c.rob_idx = m_flight[k].idx;
        end
        predict(d, c);
        dispatch <= d;
        cdb      <= c;
    endtask

    initial begin
        rst      = 1'b1;
        dispatch = '0;
        cdb      = '0;
        model_reset();
        predict('0, '0);
        repeat (3) @(posedge clock);
        rst <= 1'b0;
        for (int cyc = 0; cyc < STIM_CYCLES; cyc++) begin
            @(posedge clock);
            model_step();
            set_phase(cyc);
            drive_next();
        end
        @(posedge clock);
        #1; // action blocks of the last edge
        $display("errors: dispatch_ready %0d, rename %0d, retire %0d, committed_map %0d",
                 err_ready, err_rename, err_retire, err_map);
        if (err_ready + err_rename + err_retire + err_map == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        while (cycle_count < LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", LIMIT);
        $display("test failed");
        $finish;
    end

    a_ready: assert property (@(posedge clock) disable iff (rst)
        dispatch_ready == exp_ready)
        else begin
            err_ready++;
            $display("error %s dispatch_ready: expected %0b actual %0b",
                     test_name, $sampled(exp_ready), $sampled(dispatch_ready));
        end

    a_rename: assert property (@(posedge clock) disable iff (rst)
        strip_rd(rename) == strip_rd(exp_rename))
        else begin
            err_rename++;
            $display("error %s rename: expected %h actual %h",
                     test_name, $sampled(exp_rename), $sampled(rename));
        end

    a_rd_preg: assert property (@(posedge clock) disable iff (rst)
        exp_rd_known |-> (rename.rd_preg == exp_rename.rd_preg))
        else begin
            err_rename++;
            $display("error %s rd_preg: expected %0d actual %0d",
                     test_name, $sampled(exp_rename.rd_preg), $sampled(rename.rd_preg));
        end

    a_retire_valid: assert property (@(posedge clock) disable iff (rst)
        retire.valid == exp_retire.valid)
        else begin
            err_retire++;
            $display("error %s retire.valid: expected %0b actual %0b",
                     test_name, $sampled(exp_retire.valid), $sampled(retire.valid));
        end

    // payload only means something while valid
    a_retire: assert property (@(posedge clock) disable iff (rst)
        exp_retire.valid |-> (retire == exp_retire))
        else begin
            err_retire++;
            $display("error %s retire: expected %h actual %h",
                     test_name, $sampled(exp_retire), $sampled(retire));
        end

    a_committed: assert property (@(posedge clock) disable iff (rst)
        committed_map == exp_committed)
        else begin
            err_map++;
            $display("error %s committed_map: expected %h actual %h",
                     test_name, $sampled(exp_committed), $sampled(committed_map));
        end

endmodule

`default_nettype wire
